//--- xv_pkg.sv
/* Video generator shared definitions */
`default_nettype none

package xv_pkg;

typedef logic [15:0]    word_t;         // data and VRAM address word
typedef logic [7:0]     color_t;        // palette index
typedef logic [4:0]     hres_t;         // horizontal counter
typedef logic [3:0]     vres_t;         // vertical counter
typedef logic [4:0]     xr_num_t;       // register number

// GFX_CTRL register word, as a raw word or as its fields
typedef union packed {
    word_t              raw;
    struct packed {
        color_t         colorbase;      // XOR applied to every plane pixel
        logic           blank;          // plane off, no fetches
        logic [6:0]     unused;
    } gfx;
} xr_word_u;

// tiny video mode, sync active high
localparam int VISIBLE_WIDTH    = 16;
localparam int TOTAL_WIDTH      = 24;
localparam int HSYNC_START      = 18;
localparam int HSYNC_WIDTH      = 2;
localparam int VISIBLE_HEIGHT   = 6;
localparam int TOTAL_HEIGHT     = 9;
localparam int VSYNC_LINE       = 7;

localparam int FETCH_BEGIN      = 16;                   // prefetch of next line starts here
localparam int FIFO_DEPTH       = 4;                    // words held or in flight per plane
localparam int LINE_WORDS       = VISIBLE_WIDTH / 2;    // two 8-bit pixels per word

// register numbers
localparam xr_num_t XR_VID_CTRL     = 5'd0;
localparam xr_num_t XR_VID_INTR     = 5'd1;
localparam xr_num_t XR_SCANLINE     = 5'd2;
localparam xr_num_t XR_VID_HSIZE    = 5'd3;
localparam xr_num_t XR_VID_VSIZE    = 5'd4;
localparam xr_num_t XR_PA_GFX_CTRL  = 5'd16;
localparam xr_num_t XR_PA_DISP_ADDR = 5'd17;
localparam xr_num_t XR_PA_LINE_LEN  = 5'd18;
localparam xr_num_t XR_PB_GFX_CTRL  = 5'd24;
localparam xr_num_t XR_PB_DISP_ADDR = 5'd25;
localparam xr_num_t XR_PB_LINE_LEN  = 5'd26;

// reset values
localparam color_t  BORDER_RESET    = 8'h08;            // dark grey
localparam word_t   LINE_LEN_RESET  = 16'd8;

endpackage

`default_nettype wire

//--- video_timing.sv
/* Raster sync and blank timing */
`timescale 1ns/1ps
`default_nettype none

module video_timing
    import xv_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    output hres_t       h_count_o,
    output vres_t       v_count_o,
    output logic        h_visible_o,
    output logic        v_visible_o,
    output logic        de_next_o,          // next value of dv_de_o
    output logic        end_of_line_o,
    output logic        end_of_frame_o,
    output logic        end_of_visible_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

assign h_visible_o      = (h_count_o < hres_t'(VISIBLE_WIDTH));
assign v_visible_o      = (v_count_o < vres_t'(VISIBLE_HEIGHT));
assign de_next_o        = h_visible_o && v_visible_o;
assign end_of_line_o    = (h_count_o == hres_t'(TOTAL_WIDTH - 1));
assign end_of_frame_o   = end_of_line_o && (v_count_o == vres_t'(TOTAL_HEIGHT - 1));
assign end_of_visible_o = (h_count_o == hres_t'(VISIBLE_WIDTH - 1))
                       && (v_count_o == vres_t'(VISIBLE_HEIGHT - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o   <= '0;
        v_count_o   <= '0;
        hsync_o     <= 1'b0;
        vsync_o     <= 1'b0;
        dv_de_o     <= 1'b0;
    end else begin
        h_count_o   <= end_of_line_o ? '0 : h_count_o + 1'b1;
        if (end_of_frame_o) begin
            v_count_o   <= '0;
        end else if (end_of_line_o) begin
            v_count_o   <= v_count_o + 1'b1;
        end
        // outputs lag the counters by one clock
        hsync_o     <= (h_count_o >= hres_t'(HSYNC_START))
                    && (h_count_o < hres_t'(HSYNC_START + HSYNC_WIDTH));
        vsync_o     <= (v_count_o == vres_t'(VSYNC_LINE));
        dv_de_o     <= de_next_o;
    end
end

// sync pulse must sit entirely in the blanking interval
hsync_outside_visible: assert property (@(posedge clk) disable iff (reset_i)
    hsync_o |-> !dv_de_o);

endmodule

`default_nettype wire

//--- video_regs.sv
/* Video control registers */
`timescale 1ns/1ps
`default_nettype none

module video_regs
    import xv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_en_i,
    input  wire xr_num_t    reg_num_i,
    input  wire word_t      reg_data_i,
    output word_t           reg_data_o,
    input  wire vres_t      v_count_i,
    input  wire logic       end_of_visible_i,
    output logic            video_intr_o,
    output color_t          border_color_o,
    output logic            pa_blank_o,
    output color_t          pa_colorbase_o,
    output word_t           pa_start_addr_o,
    output word_t           pa_line_len_o,
    output logic            pb_blank_o,
    output color_t          pb_colorbase_o,
    output word_t           pb_start_addr_o,
    output word_t           pb_line_len_o
);

xr_word_u   wr_word;
word_t      rd_word;

// rebuild a GFX_CTRL word, unused bits read as zero
function automatic word_t gfx_word(input color_t colorbase, input logic blank);
    xr_word_u w;
    w.gfx.colorbase = colorbase;
    w.gfx.blank     = blank;
    w.gfx.unused    = '0;
    return w.raw;
endfunction

assign wr_word = xr_word_u'(reg_data_i);

always_ff @(posedge clk) begin
    if (reset_i) begin
        video_intr_o    <= 1'b0;
        border_color_o  <= BORDER_RESET;
        pa_blank_o      <= 1'b1;
        pa_colorbase_o  <= '0;
        pa_start_addr_o <= '0;
        pa_line_len_o   <= LINE_LEN_RESET;
        pb_blank_o      <= 1'b1;
        pb_colorbase_o  <= '0;
        pb_start_addr_o <= '0;
        pb_line_len_o   <= LINE_LEN_RESET;
    end else begin
        // end of visible area, or forced by host
        video_intr_o    <= end_of_visible_i || (reg_wr_en_i && reg_num_i == XR_VID_INTR);
        if (reg_wr_en_i) begin
            case (reg_num_i)
                XR_VID_CTRL:        border_color_o  <= wr_word.raw[7:0];
                XR_PA_GFX_CTRL: begin
                    pa_colorbase_o  <= wr_word.gfx.colorbase;
                    pa_blank_o      <= wr_word.gfx.blank;
                end
                XR_PA_DISP_ADDR:    pa_start_addr_o <= wr_word.raw;
                XR_PA_LINE_LEN:     pa_line_len_o   <= wr_word.raw;
                XR_PB_GFX_CTRL: begin
                    pb_colorbase_o  <= wr_word.gfx.colorbase;
                    pb_blank_o      <= wr_word.gfx.blank;
                end
                XR_PB_DISP_ADDR:    pb_start_addr_o <= wr_word.raw;
                XR_PB_LINE_LEN:     pb_line_len_o   <= wr_word.raw;
                default: ;                              // read-only or unused
            endcase
        end
    end
end

always_comb begin
    case (reg_num_i)
        XR_VID_CTRL:        rd_word = {8'h00, border_color_o};
        XR_SCANLINE:        rd_word = word_t'(v_count_i);
        XR_VID_HSIZE:       rd_word = word_t'(VISIBLE_WIDTH);
        XR_VID_VSIZE:       rd_word = word_t'(VISIBLE_HEIGHT);
        XR_PA_GFX_CTRL:     rd_word = gfx_word(pa_colorbase_o, pa_blank_o);
        XR_PA_DISP_ADDR:    rd_word = pa_start_addr_o;
        XR_PA_LINE_LEN:     rd_word = pa_line_len_o;
        XR_PB_GFX_CTRL:     rd_word = gfx_word(pb_colorbase_o, pb_blank_o);
        XR_PB_DISP_ADDR:    rd_word = pb_start_addr_o;
        XR_PB_LINE_LEN:     rd_word = pb_line_len_o;
        default:            rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_word;                              // readback one clock later
end

endmodule

`default_nettype wire

//--- video_playfield.sv
/* Bitmap playfield plane */
`timescale 1ns/1ps
`default_nettype none

module video_playfield
    import xv_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   blank_i,
    input  wire word_t  start_addr_i,
    input  wire word_t  line_len_i,
    input  wire color_t colorbase_i,
    input  wire color_t border_color_i,
    input  wire hres_t  h_count_i,
    input  wire logic   end_of_line_i,
    input  wire logic   end_of_frame_i,
    input  wire logic   v_visible_i,
    input  wire logic   de_next_i,
    output logic        req_o,
    output word_t       addr_o,
    input  wire logic   grant_i,
    input  wire logic   rvalid_i,
    input  wire word_t  rdata_i,
    output color_t      color_index_o
);

word_t                          fifo_mem [FIFO_DEPTH];
logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr;
logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr;
logic [$clog2(FIFO_DEPTH):0]    stored;         // words in the FIFO
logic [$clog2(FIFO_DEPTH):0]    reserved;       // words in the FIFO plus reads in flight
logic [$clog2(LINE_WORDS):0]    fetch_cnt;      // words still to read for this line
word_t                          line_addr;      // first word of the current line
vres_t                          line_cnt;
logic                           active;         // frame started while unblanked
logic                           last_line;
logic                           next_visible;
logic                           fetch_start;
logic                           issue;
logic                           push;
logic                           pop;
color_t                         pixel;

assign last_line    = (line_cnt == vres_t'(TOTAL_HEIGHT - 1));
assign next_visible = v_visible_i && (line_cnt != vres_t'(VISIBLE_HEIGHT - 1));
assign fetch_start  = !blank_i && (h_count_i == hres_t'(FETCH_BEGIN))
                   && (last_line || (active && next_visible));

assign req_o    = !blank_i && (fetch_cnt != '0) && (reserved < FIFO_DEPTH);
assign issue    = req_o && grant_i;
assign push     = rvalid_i && active;
assign pop      = de_next_i && active && h_count_i[0];  // low byte is the last of a word
assign pixel    = h_count_i[0] ? fifo_mem[rd_ptr][7:0] : fifo_mem[rd_ptr][15:8];

always_ff @(posedge clk) begin
    if (reset_i || blank_i) begin
        active      <= 1'b0;
        fetch_cnt   <= '0;
        reserved    <= '0;
        stored      <= '0;
        wr_ptr      <= '0;
        rd_ptr      <= '0;
    end else begin
        if (fetch_start) begin
            active      <= 1'b1;
            fetch_cnt   <= $bits(fetch_cnt)'(LINE_WORDS);
        end else if (issue) begin
            fetch_cnt   <= fetch_cnt - 1'b1;
        end
        reserved    <= reserved + $bits(reserved)'(issue) - $bits(reserved)'(pop);
        stored      <= stored + $bits(stored)'(push) - $bits(stored)'(pop);
        wr_ptr      <= wr_ptr + push;
        rd_ptr      <= rd_ptr + pop;
    end
end

always_ff @(posedge clk) begin
    if (reset_i || end_of_frame_i) begin
        line_cnt    <= '0;
    end else if (end_of_line_i) begin
        line_cnt    <= line_cnt + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (end_of_frame_i) begin
        line_addr   <= start_addr_i;
    end else if (end_of_line_i) begin
        line_addr   <= line_addr + line_len_i;
    end
    // line 0 is fetched on the last line, before line_addr reloads
    if (fetch_start) begin
        addr_o      <= last_line ? start_addr_i : line_addr + line_len_i;
    end else if (issue) begin
        addr_o      <= addr_o + 1'b1;
    end
    if (push) begin
        fifo_mem[wr_ptr] <= rdata_i;
    end
    color_index_o   <= ((de_next_i && active) ? pixel : border_color_i) ^ colorbase_i;
end

fifo_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
    push |-> stored != FIFO_DEPTH);

// prefetch must stay ahead of the beam on every visible pixel
fifo_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
    (de_next_i && active && !blank_i) |-> stored != '0);

endmodule

`default_nettype wire

//--- vram_arbiter.sv
/* VRAM read arbiter */
`timescale 1ns/1ps
`default_nettype none

module vram_arbiter
    import xv_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   pa_req_i,
    input  wire word_t  pa_addr_i,
    output logic        pa_grant_o,
    output logic        pa_rvalid_o,
    input  wire logic   pb_req_i,
    input  wire word_t  pb_addr_i,
    output logic        pb_grant_o,
    output logic        pb_rvalid_o,
    output logic        vram_sel_o,
    output word_t       vram_addr_o
);

assign pa_grant_o   = pa_req_i;                 // plane A never waits
assign pb_grant_o   = pb_req_i && !pa_req_i;    // plane B stalls behind A
assign vram_sel_o   = pa_req_i || pb_req_i;
assign vram_addr_o  = pa_req_i ? pa_addr_i : pb_addr_i;

// owner of the word returning next clock
always_ff @(posedge clk) begin
    if (reset_i) begin
        pa_rvalid_o <= 1'b0;
        pb_rvalid_o <= 1'b0;
    end else begin
        pa_rvalid_o <= pa_grant_o;
        pb_rvalid_o <= pb_grant_o;
    end
end

one_grant: assert property (@(posedge clk) disable iff (reset_i)
    !(pa_grant_o && pb_grant_o));

endmodule

`default_nettype wire

//--- video_gen.sv
/* Video generator top level */
`timescale 1ns/1ps
`default_nettype none

module video_gen
    import xv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_en_i,
    input  wire xr_num_t    reg_num_i,
    input  wire word_t      reg_data_i,
    output word_t           reg_data_o,
    output logic            vram_sel_o,
    output word_t           vram_addr_o,
    input  wire word_t      vram_data_i,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o,
    output logic            h_blank_o,
    output logic            v_blank_o,
    output logic            video_intr_o,
    output color_t          color_a_index_o,
    output color_t          color_b_index_o
);

hres_t      h_count;
vres_t      v_count;
logic       h_visible;
logic       v_visible;
logic       de_next;
logic       end_of_line;
logic       end_of_frame;
logic       end_of_visible;
color_t     border_color;
logic       pa_blank;
color_t     pa_colorbase;
word_t      pa_start_addr;
word_t      pa_line_len;
logic       pb_blank;
color_t     pb_colorbase;
word_t      pb_start_addr;
word_t      pb_line_len;
logic       pa_req;
word_t      pa_addr;
logic       pa_grant;
logic       pa_rvalid;
logic       pb_req;
word_t      pb_addr;
logic       pb_grant;
logic       pb_rvalid;

assign h_blank_o = ~h_visible;
assign v_blank_o = ~v_visible;

video_timing video_timing (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_o(h_count),
    .v_count_o(v_count),
    .h_visible_o(h_visible),
    .v_visible_o(v_visible),
    .de_next_o(de_next),
    .end_of_line_o(end_of_line),
    .end_of_frame_o(end_of_frame),
    .end_of_visible_o(end_of_visible),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .dv_de_o(dv_de_o)
);

video_regs video_regs (
    .clk(clk),
    .reset_i(reset_i),
    .reg_wr_en_i(reg_wr_en_i),
    .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i),
    .reg_data_o(reg_data_o),
    .v_count_i(v_count),
    .end_of_visible_i(end_of_visible),
    .video_intr_o(video_intr_o),
    .border_color_o(border_color),
    .pa_blank_o(pa_blank),
    .pa_colorbase_o(pa_colorbase),
    .pa_start_addr_o(pa_start_addr),
    .pa_line_len_o(pa_line_len),
    .pb_blank_o(pb_blank),
    .pb_colorbase_o(pb_colorbase),
    .pb_start_addr_o(pb_start_addr),
    .pb_line_len_o(pb_line_len)
);

video_playfield pf_a (
    .clk(clk),
    .reset_i(reset_i),
    .blank_i(pa_blank),
    .start_addr_i(pa_start_addr),
    .line_len_i(pa_line_len),
    .colorbase_i(pa_colorbase),
    .border_color_i(border_color),
    .h_count_i(h_count),
    .end_of_line_i(end_of_line),
    .end_of_frame_i(end_of_frame),
    .v_visible_i(v_visible),
    .de_next_i(de_next),
    .req_o(pa_req),
    .addr_o(pa_addr),
    .grant_i(pa_grant),
    .rvalid_i(pa_rvalid),
    .rdata_i(vram_data_i),
    .color_index_o(color_a_index_o)
);

video_playfield pf_b (
    .clk(clk),
    .reset_i(reset_i),
    .blank_i(pb_blank),
    .start_addr_i(pb_start_addr),
    .line_len_i(pb_line_len),
    .colorbase_i(pb_colorbase),
    .border_color_i(border_color),
    .h_count_i(h_count),
    .end_of_line_i(end_of_line),
    .end_of_frame_i(end_of_frame),
    .v_visible_i(v_visible),
    .de_next_i(de_next),
    .req_o(pb_req),
    .addr_o(pb_addr),
    .grant_i(pb_grant),
    .rvalid_i(pb_rvalid),
    .rdata_i(vram_data_i),
    .color_index_o(color_b_index_o)
);

vram_arbiter vram_arbiter (
    .clk(clk),
    .reset_i(reset_i),
    .pa_req_i(pa_req),
    .pa_addr_i(pa_addr),
    .pa_grant_o(pa_grant),
    .pa_rvalid_o(pa_rvalid),
    .pb_req_i(pb_req),
    .pb_addr_i(pb_addr),
    .pb_grant_o(pb_grant),
    .pb_rvalid_o(pb_rvalid),
    .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o)
);

endmodule

`default_nettype wire

//--- tb_vram_model.sv
/* VRAM model for simulation */
`timescale 1ns/1ps
`default_nettype none

module tb_vram_model
    import xv_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   sel_i,
    input  wire word_t  addr_i,
    output word_t       data_o
);

// contents are a fixed function of the full address, no storage needed
always_ff @(posedge clk) begin
    if (sel_i) begin
        data_o <= addr_i ^ 16'hA55A;        // one clock read latency
    end
end

endmodule

`default_nettype wire

//--- tb_video_gen.sv
/* Video generator testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_video_gen
    import xv_pkg::*;
();

localparam int FRAME_CLOCKS = TOTAL_WIDTH * TOTAL_HEIGHT;

logic       clk;
logic       reset;
logic       reg_wr_en;
xr_num_t    reg_num;
word_t      reg_data;
word_t      rd_data;
logic       vram_sel;
word_t      vram_addr;
word_t      vram_data;
logic       hsync;
logic       vsync;
logic       dv_de;
logic       h_blank;
logic       v_blank;
logic       video_intr;
color_t     color_a;
color_t     color_b;

int         ref_h;              // mirror of the DUT pixel counter
int         ref_v;
int         pix_h;              // position of the pixel now on the outputs
int         pix_v;
logic       intr_wr_d;
logic       rd_check;
logic       rd_chk_d;
word_t      rd_expect;
word_t      rd_exp_d;
logic       px_check;
word_t      shadow [32];        // expected register contents
logic       exp_de;
logic       exp_hs;
logic       exp_vs;
logic       exp_hb;
logic       exp_vb;
logic       exp_intr;
color_t     exp_a;
color_t     exp_b;
int         errors;
int         failed;
int         tests;
int         err_mark;
string      cur_test;
xr_num_t    writable [7] = '{XR_VID_CTRL, XR_PA_GFX_CTRL, XR_PA_DISP_ADDR, XR_PA_LINE_LEN,
                             XR_PB_GFX_CTRL, XR_PB_DISP_ADDR, XR_PB_LINE_LEN};

video_gen dut (
    .clk(clk),
    .reset_i(reset),
    .reg_wr_en_i(reg_wr_en),
    .reg_num_i(reg_num),
    .reg_data_i(reg_data),
    .reg_data_o(rd_data),
    .vram_sel_o(vram_sel),
    .vram_addr_o(vram_addr),
    .vram_data_i(vram_data),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .dv_de_o(dv_de),
    .h_blank_o(h_blank),
    .v_blank_o(v_blank),
    .video_intr_o(video_intr),
    .color_a_index_o(color_a),
    .color_b_index_o(color_b)
);

tb_vram_model vram (
    .clk(clk),
    .sel_i(vram_sel),
    .addr_i(vram_addr),
    .data_o(vram_data)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

function automatic word_t vram_word(input word_t addr);
    return addr ^ 16'hA55A;
endfunction

// expected color of one plane: high byte first, XOR colorbase
function automatic color_t plane_pixel(input word_t ctrl, input word_t start, input word_t len,
                                       input color_t border, input int h, input int v);
    word_t  w;
    color_t px;
    px = border;
    if (!ctrl[7] && h < VISIBLE_WIDTH && v < VISIBLE_HEIGHT) begin
        w  = vram_word(start + word_t'(v) * len + word_t'(h / 2));
        px = (h % 2 == 1) ? w[7:0] : w[15:8];
    end
    return px ^ ctrl[15:8];
endfunction

always_ff @(posedge clk) begin
    if (reset) begin
        ref_h       <= 0;
        ref_v       <= 0;
        pix_h       <= VISIBLE_WIDTH;       // outside the visible area
        pix_v       <= 0;
        intr_wr_d   <= 1'b0;
        rd_chk_d    <= 1'b0;
        rd_exp_d    <= '0;
    end else begin
        pix_h       <= ref_h;
        pix_v       <= ref_v;
        ref_h       <= (ref_h == TOTAL_WIDTH - 1) ? 0 : ref_h + 1;
        if (ref_h == TOTAL_WIDTH - 1) begin
            ref_v   <= (ref_v == TOTAL_HEIGHT - 1) ? 0 : ref_v + 1;
        end
        intr_wr_d   <= reg_wr_en && (reg_num == XR_VID_INTR);
        rd_chk_d    <= rd_check;
        rd_exp_d    <= (reg_num == XR_SCANLINE) ? word_t'(ref_v) : rd_expect;
    end
end

always_comb begin
    exp_de   = (pix_h < VISIBLE_WIDTH) && (pix_v < VISIBLE_HEIGHT);
    exp_hs   = (pix_h >= HSYNC_START) && (pix_h < HSYNC_START + HSYNC_WIDTH);
    exp_vs   = (pix_v == VSYNC_LINE);
    exp_hb   = (ref_h >= VISIBLE_WIDTH);    // blank outputs follow the counters directly
    exp_vb   = (ref_v >= VISIBLE_HEIGHT);
    exp_intr = ((pix_h == VISIBLE_WIDTH - 1) && (pix_v == VISIBLE_HEIGHT - 1)) || intr_wr_d;
    exp_a    = plane_pixel(shadow[XR_PA_GFX_CTRL], shadow[XR_PA_DISP_ADDR],
                           shadow[XR_PA_LINE_LEN], color_t'(shadow[XR_VID_CTRL]), pix_h, pix_v);
    exp_b    = plane_pixel(shadow[XR_PB_GFX_CTRL], shadow[XR_PB_DISP_ADDR],
                           shadow[XR_PB_LINE_LEN], color_t'(shadow[XR_VID_CTRL]), pix_h, pix_v);
end

task automatic report_value(input string what, input word_t expected, input word_t actual);
    errors++;
    $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, expected, actual);
endtask

de_shape: assert property (@(posedge clk) disable iff (reset) dv_de == exp_de)
    else report_value("dv_de_o", word_t'($sampled(exp_de)), word_t'($sampled(dv_de)));
hsync_shape: assert property (@(posedge clk) disable iff (reset) hsync == exp_hs)
    else report_value("hsync_o", word_t'($sampled(exp_hs)), word_t'($sampled(hsync)));
vsync_shape: assert property (@(posedge clk) disable iff (reset) vsync == exp_vs)
    else report_value("vsync_o", word_t'($sampled(exp_vs)), word_t'($sampled(vsync)));
hblank_shape: assert property (@(posedge clk) disable iff (reset) h_blank == exp_hb)
    else report_value("h_blank_o", word_t'($sampled(exp_hb)), word_t'($sampled(h_blank)));
vblank_shape: assert property (@(posedge clk) disable iff (reset) v_blank == exp_vb)
    else report_value("v_blank_o", word_t'($sampled(exp_vb)), word_t'($sampled(v_blank)));
intr_pulse: assert property (@(posedge clk) disable iff (reset) video_intr == exp_intr)
    else report_value("video_intr_o", word_t'($sampled(exp_intr)), word_t'($sampled(video_intr)));
readback: assert property (@(posedge clk) disable iff (reset) rd_chk_d |-> rd_data == rd_exp_d)
    else report_value("reg_data_o", $sampled(rd_exp_d), $sampled(rd_data));
pixel_a: assert property (@(posedge clk) disable iff (reset) px_check |-> color_a == exp_a)
    else report_value("color_a_index_o", word_t'($sampled(exp_a)), word_t'($sampled(color_a)));
pixel_b: assert property (@(posedge clk) disable iff (reset) px_check |-> color_b == exp_b)
    else report_value("color_b_index_o", word_t'($sampled(exp_b)), word_t'($sampled(color_b)));

task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("=== FAIL ===");
    $finish;
endtask

task automatic write_reg(input xr_num_t num, input word_t data);
    @(posedge clk);
    reg_wr_en   <= 1'b1;
    reg_num     <= num;
    reg_data    <= data;
    @(posedge clk);
    reg_wr_en   <= 1'b0;
    case (num)
        XR_VID_CTRL:                        shadow[num] = data & 16'h00FF;
        XR_PA_GFX_CTRL, XR_PB_GFX_CTRL:     shadow[num] = data & 16'hFF80;
        XR_PA_DISP_ADDR, XR_PA_LINE_LEN,
        XR_PB_DISP_ADDR, XR_PB_LINE_LEN:    shadow[num] = data;
        default: ;
    endcase
endtask

task automatic read_expect(input xr_num_t num, input word_t value);
    @(posedge clk);
    reg_num     <= num;
    rd_expect   <= value;
    rd_check    <= 1'b1;
    @(posedge clk);
    rd_check    <= 1'b0;
endtask

task automatic wait_frame_end();
    int   n;
    logic found;
    found = 1'b0;
    for (n = 0; n < FRAME_CLOCKS + 8 && !found; n++) begin
        @(posedge clk);
        found = (ref_h == TOTAL_WIDTH - 1) && (ref_v == TOTAL_HEIGHT - 1);
    end
    if (!found) abort_run("no end of frame seen within one frame time");
endtask

task automatic wait_intr(input int limit, input string why);
    int   n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < limit && !seen; n++) begin
        @(negedge clk);
        seen = video_intr;
    end
    if (!seen) abort_run(why);
endtask

task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
endtask

task automatic finish_test();
    @(negedge clk);                         // let the last assertions report
    tests++;
    if (errors == err_mark) begin
        $display("test %s: ok", cur_test);
    end else begin
        failed++;
        $display("test %s: failed with %0d errors", cur_test, errors - err_mark);
    end
endtask

// configure plane A enabled, plane B as given, then check two full frames
task automatic run_planes(input logic b_on);
    word_t a_start;
    a_start = word_t'($urandom());
    px_check <= 1'b0;
    write_reg(XR_VID_CTRL, word_t'($urandom()));
    write_reg(XR_PA_DISP_ADDR, a_start);
    write_reg(XR_PA_LINE_LEN, word_t'($urandom_range(1, 64)));
    write_reg(XR_PA_GFX_CTRL, {color_t'($urandom()), 8'h00});
    write_reg(XR_PB_DISP_ADDR, a_start ^ 16'h8000);
    write_reg(XR_PB_LINE_LEN, word_t'($urandom_range(1, 64)));
    write_reg(XR_PB_GFX_CTRL, {color_t'($urandom()), b_on ? 8'h00 : 8'h80});
    wait_frame_end();
    wait_frame_end();
    px_check <= 1'b1;
    wait_frame_end();
    wait_frame_end();
    px_check <= 1'b0;
endtask

initial begin
    void'($urandom(32'hbe06_96b2));        // one seed for the whole run
    reset       <= 1'b1;
    reg_wr_en   <= 1'b0;
    reg_num     <= '0;
    reg_data    <= '0;
    rd_check    <= 1'b0;
    rd_expect   <= '0;
    px_check    <= 1'b0;
    errors      = 0;
    failed      = 0;
    tests       = 0;
    for (int r = 0; r < 32; r++) shadow[r] = '0;
    shadow[XR_VID_CTRL]     = word_t'(BORDER_RESET);
    shadow[XR_VID_HSIZE]    = word_t'(VISIBLE_WIDTH);
    shadow[XR_VID_VSIZE]    = word_t'(VISIBLE_HEIGHT);
    shadow[XR_PA_GFX_CTRL]  = 16'h0080;     // blanked
    shadow[XR_PB_GFX_CTRL]  = 16'h0080;
    shadow[XR_PA_LINE_LEN]  = LINE_LEN_RESET;
    shadow[XR_PB_LINE_LEN]  = LINE_LEN_RESET;
    start_test("reset_readback");
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (int r = 0; r < 32; r++) read_expect(xr_num_t'(r), shadow[r]);
    finish_test();

    start_test("sync_shape");
    repeat (8) begin
        repeat ($urandom_range(1, 40)) @(posedge clk);
        read_expect(XR_SCANLINE, '0);
    end
    wait_frame_end();
    finish_test();

    start_test("register_rw");
    for (int i = 0; i < 7; i++) write_reg(writable[i], word_t'($urandom()));
    for (int i = 0; i < 7; i++) read_expect(writable[i], shadow[writable[i]]);
    finish_test();

    start_test("plane_a_pixels");
    run_planes(1'b0);
    finish_test();

    start_test("both_planes");
    run_planes(1'b1);
    finish_test();

    start_test("interrupt");
    wait_intr(FRAME_CLOCKS + 8, "no end of visible interrupt within a frame");
    repeat (10) @(posedge clk);
    write_reg(XR_VID_INTR, '0);
    wait_intr(4, "no interrupt after a VID_INTR write");
    wait_frame_end();
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (failed == 0 && errors == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- all.f
xv_pkg.sv
video_timing.sv
video_regs.sv
video_playfield.sv
vram_arbiter.sv
video_gen.sv
tb_vram_model.sv
tb_video_gen.sv

//--- Makefile
# Verilator build and run for the video generator testbench

VERILATOR ?= verilator
TOP       ?= tb_video_gen
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
